// ==== common/rv_core_pkg.sv ====
// shared widths, opcodes and instruction views for the single-cycle rv64 core
// every rtl file refers to these through rv_core_pkg:: scoped names
package rv_core_pkg;

  // datapath and instruction widths
  localparam int xlen           = 64;
  localparam int inst_width     = 32;
  localparam int reg_id_width   = 5;

  // word memory, 4 kB of 32-bit words
  localparam int mem_words      = 1024;
  localparam int mem_addr_width = 10;

  // pc after reset, also the base address of the memory
  localparam logic [xlen-1:0] pc_reset = 64'h0000_0000_8000_0000;

  // major opcodes of the supported subset
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_op_imm = 7'b0010011;
  localparam logic [6:0] op_op     = 7'b0110011;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_system = 7'b1110011;

  // ebreak is matched on the whole word
  localparam logic [inst_width-1:0] ebreak_word = 32'h0010_0073;

  // field views of the base formats, msb first
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_type_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_type_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } s_type_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_type_t;

  // jal immediate bits are scrambled in the word
  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_type_t;

  // one instruction word, read through whichever format applies
  typedef union packed {
    r_type_t r;
    i_type_t i;
    s_type_t s;
    u_type_t u;
    j_type_t j;
  } inst_u;

  // decoded control, one instruction's worth
  typedef struct packed {
    logic reg_wen;
    logic need_imm;
    logic pc_operand;   // auipc adds to the pc
    logic zero_operand; // lui adds to zero
    logic is_jal;
    logic mem_wen;
    logic is_ebreak;
    logic is_illegal;
  } ctrl_t;

  // doubleword store toward memory and the top level
  typedef struct packed {
    logic            valid;
    logic [xlen-1:0] addr;
    logic [xlen-1:0] data;
    logic [7:0]      mask;
  } store_req_t;

  // program load port, one word per edge
  typedef struct packed {
    logic                      en;
    logic [mem_addr_width-1:0] index;
    logic [inst_width-1:0]     data;
  } prog_load_t;

endpackage

// ==== logic/fetch.sv ====
// pc register with next-pc select and the halted / illegal flags
// the pc stops for good on ebreak or an illegal word until reset
`timescale 1ns/1ps

module fetch (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              jump_taken,
  input  logic [rv_core_pkg::xlen-1:0]      jump_target,
  input  rv_core_pkg::ctrl_t                ctrl,
  output logic [rv_core_pkg::xlen-1:0]      current_pc,
  output logic                              halted,
  output logic                              illegal
);

  logic [rv_core_pkg::xlen-1:0] next_pc;

  // jal redirects, everything else falls through
  assign next_pc = jump_taken ? jump_target : current_pc + 64'd4;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      current_pc <= rv_core_pkg::pc_reset;
      halted     <= 1'b0;
      illegal    <= 1'b0;
    end else if (!halted) begin
      if (ctrl.is_ebreak || ctrl.is_illegal) begin
        // pc stays on the stopping word
        halted  <= 1'b1;
        illegal <= ctrl.is_illegal;
      end else begin
        current_pc <= next_pc;
      end
    end
  end

endmodule

// ==== memory/unified_memory.sv ====
// unified word memory shared by instruction fetch and sd stores
// the testbench fills it through the program load port during reset
`timescale 1ns/1ps

module unified_memory (
  input  logic                          clk,
  input  logic [rv_core_pkg::xlen-1:0]  pc,
  output rv_core_pkg::inst_u            inst,
  input  rv_core_pkg::store_req_t       store_req,
  input  rv_core_pkg::prog_load_t       prog_load
);

  // word storage, no reset
  logic [rv_core_pkg::inst_width-1:0] mem [rv_core_pkg::mem_words];

  // byte offsets from the memory base
  logic [rv_core_pkg::xlen-1:0] inst_off;
  logic [rv_core_pkg::xlen-1:0] store_off;

  // word indices
  logic [rv_core_pkg::mem_addr_width-1:0] inst_idx;
  logic [rv_core_pkg::mem_addr_width-1:0] store_lo;
  logic [rv_core_pkg::mem_addr_width-1:0] store_hi;

  assign inst_off  = pc - rv_core_pkg::pc_reset;
  assign store_off = store_req.addr - rv_core_pkg::pc_reset;

  // bits 11..2 pick the word
  assign inst_idx = inst_off[rv_core_pkg::mem_addr_width+1:2];
  assign store_lo = store_off[rv_core_pkg::mem_addr_width+1:2];
  assign store_hi = store_lo + rv_core_pkg::mem_addr_width'(1);

  // instruction read, combinational
  assign inst = mem[inst_idx];

  always_ff @(posedge clk) begin
    if (store_req.valid) begin
      // low word gets mask[3:0], high word mask[7:4]
      for (int b = 0; b < 4; b++) begin
        if (store_req.mask[b]) begin
          mem[store_lo][b*8 +: 8] <= store_req.data[b*8 +: 8];
        end
        if (store_req.mask[b+4]) begin
          mem[store_hi][b*8 +: 8] <= store_req.data[32+b*8 +: 8];
        end
      end
    end
    // load comes last so it wins on a clash
    if (prog_load.en) begin
      mem[prog_load.index] <= prog_load.data;
    end
  end

endmodule

// ==== logic/decoder.sv ====
// combinational decoder for lui, auipc, addi, add, jal, sd and ebreak
// anything else comes out as an illegal instruction
`timescale 1ns/1ps

module decoder (
  input  rv_core_pkg::inst_u                        inst,
  output logic [rv_core_pkg::reg_id_width-1:0]      rd,
  output logic [rv_core_pkg::reg_id_width-1:0]      rs1,
  output logic [rv_core_pkg::reg_id_width-1:0]      rs2,
  output logic [rv_core_pkg::xlen-1:0]              imm,
  output rv_core_pkg::ctrl_t                        ctrl
);

  // sign-extended immediates, one per format
  logic [rv_core_pkg::xlen-1:0] i_imm;
  logic [rv_core_pkg::xlen-1:0] s_imm;
  logic [rv_core_pkg::xlen-1:0] u_imm;
  logic [rv_core_pkg::xlen-1:0] j_imm;

  assign i_imm = {{52{inst.i.imm_11_0[11]}}, inst.i.imm_11_0};
  assign s_imm = {{52{inst.s.imm_11_5[6]}}, inst.s.imm_11_5, inst.s.imm_4_0};
  // u immediate fills bits 31..12, sign from bit 31
  assign u_imm = {{32{inst.u.imm_31_12[19]}}, inst.u.imm_31_12, 12'b0};
  // j immediate, lsb always zero
  assign j_imm = {{43{inst.j.imm_20}}, inst.j.imm_20, inst.j.imm_19_12,
                  inst.j.imm_11, inst.j.imm_10_1, 1'b0};

  // register fields sit at the same spot in every format
  assign rd  = inst.r.rd;
  assign rs1 = inst.r.rs1;
  assign rs2 = inst.r.rs2;

  always_comb begin
    imm  = '0;
    ctrl = '0;
    case (inst.r.opcode)
      rv_core_pkg::op_lui: begin
        // rd = 0 + imm
        ctrl.reg_wen      = 1'b1;
        ctrl.need_imm     = 1'b1;
        ctrl.zero_operand = 1'b1;
        imm               = u_imm;
      end
      rv_core_pkg::op_auipc: begin
        // rd = pc + imm
        ctrl.reg_wen    = 1'b1;
        ctrl.need_imm   = 1'b1;
        ctrl.pc_operand = 1'b1;
        imm             = u_imm;
      end
      rv_core_pkg::op_op_imm: begin
        // only addi
        if (inst.i.funct3 == 3'b000) begin
          ctrl.reg_wen  = 1'b1;
          ctrl.need_imm = 1'b1;
          imm           = i_imm;
        end else begin
          ctrl.is_illegal = 1'b1;
        end
      end
      rv_core_pkg::op_op: begin
        // only add, sub and friends rejected
        if (inst.r.funct3 == 3'b000 && inst.r.funct7 == 7'b0) begin
          ctrl.reg_wen = 1'b1;
        end else begin
          ctrl.is_illegal = 1'b1;
        end
      end
      rv_core_pkg::op_jal: begin
        ctrl.reg_wen = 1'b1;
        ctrl.is_jal  = 1'b1;
        imm          = j_imm;
      end
      rv_core_pkg::op_store: begin
        // sd only
        if (inst.s.funct3 == 3'b011) begin
          ctrl.mem_wen  = 1'b1;
          ctrl.need_imm = 1'b1;
          imm           = s_imm;
        end else begin
          ctrl.is_illegal = 1'b1;
        end
      end
      rv_core_pkg::op_system: begin
        // ecall and csr ops are not supported
        if (inst == rv_core_pkg::ebreak_word) begin
          ctrl.is_ebreak = 1'b1;
        end else begin
          ctrl.is_illegal = 1'b1;
        end
      end
      default: begin
        ctrl.is_illegal = 1'b1;
      end
    endcase
  end

endmodule

// ==== logic/reg_file.sv ====
// 32 x 64-bit integer registers, two async reads, one sync write
// x0 is hardwired to zero
`timescale 1ns/1ps

module reg_file (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  wen,
  input  logic [rv_core_pkg::reg_id_width-1:0]  rd,
  input  logic [rv_core_pkg::xlen-1:0]          wdata,
  input  logic [rv_core_pkg::reg_id_width-1:0]  rs1,
  input  logic [rv_core_pkg::reg_id_width-1:0]  rs2,
  output logic [rv_core_pkg::xlen-1:0]          rdata_1,
  output logic [rv_core_pkg::xlen-1:0]          rdata_2
);

  logic [rv_core_pkg::xlen-1:0] regs [2**rv_core_pkg::reg_id_width];

  // writes to x0 dropped, none during reset
  always_ff @(posedge clk) begin
    if (rst_n && wen && rd != '0) begin
      regs[rd] <= wdata;
    end
  end

  // x0 reads zero whatever the array holds
  assign rdata_1 = (rs1 == '0) ? '0 : regs[rs1];
  assign rdata_2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== logic/execute.sv ====
// operand muxes, the single adder, write-back select, jal target and sd request
// purely combinational, results land at the next edge
`timescale 1ns/1ps

module execute (
  input  rv_core_pkg::ctrl_t                ctrl,
  input  logic                              halted,
  input  logic [rv_core_pkg::xlen-1:0]      current_pc,
  input  logic [rv_core_pkg::xlen-1:0]      imm,
  input  logic [rv_core_pkg::xlen-1:0]      rdata_1,
  input  logic [rv_core_pkg::xlen-1:0]      rdata_2,
  input  logic                              rst_n,
  output logic                              reg_wen,
  output logic [rv_core_pkg::xlen-1:0]      reg_wdata,
  output logic                              jump_taken,
  output logic [rv_core_pkg::xlen-1:0]      jump_target,
  output rv_core_pkg::store_req_t           store_req
);

  logic [rv_core_pkg::xlen-1:0] operand_1;
  logic [rv_core_pkg::xlen-1:0] operand_2;
  logic [rv_core_pkg::xlen-1:0] sum;
  logic                         active;

  // pc for auipc, zero for lui
  assign operand_1 = ctrl.pc_operand   ? current_pc :
                     ctrl.zero_operand ? '0 : rdata_1;
  assign operand_2 = ctrl.need_imm ? imm : rdata_2;

  // addi, add, lui, auipc and the sd address all share this
  assign sum = operand_1 + operand_2;

  // no side effects in reset, after a halt, or on a stopping word
  assign active = rst_n && !halted && !ctrl.is_ebreak && !ctrl.is_illegal;

  assign reg_wen   = ctrl.reg_wen && active;
  // jal links pc + 4
  assign reg_wdata = ctrl.is_jal ? current_pc + 64'd4 : sum;

  assign jump_taken  = ctrl.is_jal;
  assign jump_target = current_pc + imm;

  // sd always writes the full doubleword
  assign store_req.valid = ctrl.mem_wen && active;
  assign store_req.addr  = sum;
  assign store_req.data  = rdata_2;
  assign store_req.mask  = 8'hff;

endmodule

// ==== logic/rv_core_top.sv ====
// top of the single-cycle core: fetch, memory, decode, registers, execute
// the testbench loads a program during reset and watches pc and stores
`timescale 1ns/1ps

module rv_core_top (
  input  logic                          clk,
  input  logic                          rst_n,
  input  rv_core_pkg::prog_load_t       prog_load,
  output logic [rv_core_pkg::xlen-1:0]  current_pc,
  output rv_core_pkg::store_req_t       store_req,
  output logic                          halted,
  output logic                          illegal
);

  // fetched word
  rv_core_pkg::inst_u inst;

  // decode results
  logic [rv_core_pkg::reg_id_width-1:0] rd;
  logic [rv_core_pkg::reg_id_width-1:0] rs1;
  logic [rv_core_pkg::reg_id_width-1:0] rs2;
  logic [rv_core_pkg::xlen-1:0]         imm;
  rv_core_pkg::ctrl_t                   ctrl;

  // register reads and write-back
  logic [rv_core_pkg::xlen-1:0] rdata_1;
  logic [rv_core_pkg::xlen-1:0] rdata_2;
  logic                         reg_wen;
  logic [rv_core_pkg::xlen-1:0] reg_wdata;

  // redirect back to fetch
  logic                         jump_taken;
  logic [rv_core_pkg::xlen-1:0] jump_target;

  fetch u_fetch (
    .clk         (clk),
    .rst_n       (rst_n),
    .jump_taken  (jump_taken),
    .jump_target (jump_target),
    .ctrl        (ctrl),
    .current_pc  (current_pc),
    .halted      (halted),
    .illegal     (illegal)
  );

  unified_memory u_memory (
    .clk       (clk),
    .pc        (current_pc),
    .inst      (inst),
    .store_req (store_req),
    .prog_load (prog_load)
  );

  decoder u_decoder (
    .inst (inst),
    .rd   (rd),
    .rs1  (rs1),
    .rs2  (rs2),
    .imm  (imm),
    .ctrl (ctrl)
  );

  reg_file u_reg_file (
    .clk     (clk),
    .rst_n   (rst_n),
    .wen     (reg_wen),
    .rd      (rd),
    .wdata   (reg_wdata),
    .rs1     (rs1),
    .rs2     (rs2),
    .rdata_1 (rdata_1),
    .rdata_2 (rdata_2)
  );

  // store_req also goes straight out as the observed store bus
  execute u_execute (
    .ctrl        (ctrl),
    .halted      (halted),
    .current_pc  (current_pc),
    .imm         (imm),
    .rdata_1     (rdata_1),
    .rdata_2     (rdata_2),
    .rst_n       (rst_n),
    .reg_wen     (reg_wen),
    .reg_wdata   (reg_wdata),
    .jump_taken  (jump_taken),
    .jump_target (jump_target),
    .store_req   (store_req)
  );

endmodule

// ==== verif/rv_core_assertions.sv ====
// concurrent checks on the core's halt and store behavior
// attached to rv_core_top through the bind at the bottom
`timescale 1ns/1ps

module rv_core_assertions (
  input logic                          clk,
  input logic                          rst_n,
  input logic                          halted,
  input logic                          illegal,
  input logic [rv_core_pkg::xlen-1:0]  current_pc,
  input rv_core_pkg::store_req_t       store_req
);

  // stores only from a running core
  store_quiet: assert property (@(posedge clk) (halted || !rst_n) |-> !store_req.valid)
    else $error("store valid while halted or in reset");

  // halted pc holds until reset
  pc_frozen: assert property (@(posedge clk) (rst_n && halted) |=> $stable(current_pc))
    else $error("pc moved while halted");

  // an illegal word always stops the core
  illegal_halts: assert property (@(posedge clk) illegal |-> halted)
    else $error("illegal set without halted");

endmodule

bind rv_core_top rv_core_assertions u_rv_core_assertions (
  .clk        (clk),
  .rst_n      (rst_n),
  .halted     (halted),
  .illegal    (illegal),
  .current_pc (current_pc),
  .store_req  (store_req)
);

// ==== verif/rv_core_tb.sv ====
// directed testbench for the single-cycle rv64 core
// loads hand-encoded programs during reset, then checks the store bus, pc and halt flags
`timescale 1ns/1ps

module rv_core_tb;

  localparam int max_cycles = 2000;

  logic                    clk;
  logic                    rst_n;
  rv_core_pkg::prog_load_t prog_load;
  logic [63:0]             current_pc;
  rv_core_pkg::store_req_t store_req;
  logic                    halted;
  logic                    illegal;

  // program image, expected results and captured bus activity
  logic [rv_core_pkg::mem_addr_width-1:0] load_index_q[$];
  logic [31:0] load_data_q[$];
  logic [63:0] store_addr_q[$];
  logic [63:0] store_data_q[$];
  logic [7:0]  store_mask_q[$];
  logic [63:0] pc_q[$];
  logic [63:0] exp_addr_q[$];
  logic [63:0] exp_data_q[$];
  logic [63:0] exp_pc_q[$];
  logic [63:0] model [32];

  int     next_index;
  int     error_count;
  int     check_count;
  int     cycle_count;
  integer seed = 10;

  rv_core_top u_rv_core_top (
    .clk        (clk),
    .rst_n      (rst_n),
    .prog_load  (prog_load),
    .current_pc (current_pc),
    .store_req  (store_req),
    .halted     (halted),
    .illegal    (illegal)
  );

  always #10 clk = ~clk;

  // pc of each executed word and every valid store as seen before the edge
  always @(posedge clk) begin
    if (rst_n && !halted) begin
      pc_q.push_back(current_pc);
    end
    if (store_req.valid) begin
      store_addr_q.push_back(store_req.addr);
      store_data_q.push_back(store_req.data);
      store_mask_q.push_back(store_req.mask);
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= max_cycles) begin
      $display("timeout: the run went past %0d cycles without finishing", max_cycles);
      $display("Done: errors found");
      $finish;
    end
  end

  // rv64i encodings with fields msb first
  function automatic logic [31:0] enc_lui(input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, 7'b0110111};
  endfunction

  function automatic logic [31:0] enc_auipc(input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, 7'b0010111};
  endfunction

  function automatic logic [31:0] enc_addi(input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] enc_add(input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
    return {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_sd(input logic [4:0] rs1, input logic [4:0] rs2,
                                         input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], 7'b0100011};
  endfunction

  // byte offset with bit 0 dropped
  function automatic logic [31:0] enc_jal(input logic [4:0] rd, input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  function automatic logic [63:0] sext12(input logic [11:0] v);
    return {{52{v[11]}}, v};
  endfunction

  function automatic logic [4:0] pick_reg();
    int v;
    v = $unsigned($random(seed)) % 5;
    return 5'(v);
  endfunction

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("[ERROR] %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic clear_program();
    load_index_q.delete();
    load_data_q.delete();
    exp_addr_q.delete();
    exp_data_q.delete();
    exp_pc_q.delete();
    next_index = 0;
  endtask

  task automatic emit(input logic [31:0] word);
    load_index_q.push_back(10'(next_index));
    load_data_q.push_back(word);
    next_index++;
  endtask

  task automatic expect_store(input int off, input logic [63:0] data);
    exp_addr_q.push_back(rv_core_pkg::pc_reset + 64'(off));
    exp_data_q.push_back(data);
  endtask

  // at least 8 cycles in reset and longer for a long program
  task automatic reset_and_load();
    int cycles;
    cycles = (load_data_q.size() > 8) ? load_data_q.size() : 8;
    @(negedge clk);
    rst_n = 1'b0;
    for (int c = 0; c < cycles; c++) begin
      if (c < load_data_q.size()) begin
        prog_load.en    = 1'b1;
        prog_load.index = load_index_q[c];
        prog_load.data  = load_data_q[c];
      end else begin
        prog_load = '0;
      end
      @(negedge clk);
    end
    prog_load = '0;
    store_addr_q.delete();
    store_data_q.delete();
    store_mask_q.delete();
    pc_q.delete();
    rst_n = 1'b1;
  endtask

  // a few extra cycles show that pc and stores stay frozen
  task automatic run_until_halt();
    while (!halted) begin
      @(negedge clk);
    end
    repeat (3) @(negedge clk);
  endtask

  task automatic compare_stores();
    check_value("store count", 64'(store_addr_q.size()), 64'(exp_addr_q.size()));
    for (int k = 0; k < exp_addr_q.size() && k < store_addr_q.size(); k++) begin
      check_value("store addr", store_addr_q[k], exp_addr_q[k]);
      check_value("store data", store_data_q[k], exp_data_q[k]);
      check_value("store mask", 64'(store_mask_q[k]), 64'hff);
    end
  endtask

  task automatic compare_trace();
    check_value("pc trace length", 64'(pc_q.size()), 64'(exp_pc_q.size()));
    for (int k = 0; k < exp_pc_q.size() && k < pc_q.size(); k++) begin
      check_value("pc trace", pc_q[k], exp_pc_q[k]);
    end
  endtask

  task automatic check_halt(input logic exp_illegal, input int stop_off);
    check_value("halted", 64'(halted), 64'd1);
    check_value("illegal", 64'(illegal), 64'(exp_illegal));
    check_value("halt pc", current_pc, rv_core_pkg::pc_reset + 64'(stop_off));
  endtask

  task automatic test_reset_state();
    clear_program();
    emit(enc_addi(5'd1, 5'd0, 12'd1));
    for (int k = 0; k < 3; k++) begin
      emit(enc_addi(5'd1, 5'd1, 12'd1));
    end
    emit(32'h0010_0073);
    for (int k = 0; k < 5; k++) begin
      exp_pc_q.push_back(rv_core_pkg::pc_reset + 64'(4 * k));
    end
    reset_and_load();
    // let the released reset reach the store gate
    #1;
    check_value("reset pc", current_pc, rv_core_pkg::pc_reset);
    check_value("reset halted", 64'(halted), 64'd0);
    check_value("reset illegal", 64'(illegal), 64'd0);
    check_value("reset store valid", 64'(store_req.valid), 64'd0);
    run_until_halt();
    compare_trace();
    compare_stores();
    check_halt(1'b0, 16);
  endtask

  task automatic test_arithmetic();
    clear_program();
    emit(enc_auipc(5'd5, 20'h0));
    emit(enc_lui(5'd1, 20'h12345));
    emit(enc_addi(5'd1, 5'd1, 12'h678));
    emit(enc_addi(5'd2, 5'd0, 12'hffb));
    emit(enc_add(5'd3, 5'd1, 5'd2));
    // x0 as destination must stay zero
    emit(enc_addi(5'd0, 5'd1, 12'd7));
    emit(enc_lui(5'd4, 20'h80001));
    emit(enc_sd(5'd5, 5'd3, 12'h400));
    emit(enc_sd(5'd5, 5'd0, 12'h408));
    emit(enc_sd(5'd5, 5'd2, 12'h410));
    emit(enc_sd(5'd5, 5'd4, 12'h418));
    emit(32'h0010_0073);
    expect_store('h400, 64'h0000_0000_1234_5673);
    expect_store('h408, 64'h0);
    expect_store('h410, 64'hffff_ffff_ffff_fffb);
    // lui sign-extends bit 31 on rv64
    expect_store('h418, 64'hffff_ffff_8000_1000);
    reset_and_load();
    run_until_halt();
    compare_stores();
    check_halt(1'b0, 44);
  endtask

  task automatic test_auipc_jal();
    int offs [6] = '{0, 4, 8, 12, 20, 24};
    clear_program();
    emit(enc_auipc(5'd5, 20'h0));
    emit(enc_auipc(5'd6, 20'h1));
    emit(enc_sd(5'd5, 5'd6, 12'h400));
    emit(enc_jal(5'd7, 21'd8));
    // skipped by the jal
    emit(enc_sd(5'd5, 5'd5, 12'h408));
    emit(enc_sd(5'd5, 5'd7, 12'h410));
    emit(32'h0010_0073);
    expect_store('h400, 64'h0000_0000_8000_1004);
    expect_store('h410, 64'h0000_0000_8000_0010);
    foreach (offs[k]) begin
      exp_pc_q.push_back(rv_core_pkg::pc_reset + 64'(offs[k]));
    end
    reset_and_load();
    run_until_halt();
    compare_trace();
    compare_stores();
    check_halt(1'b0, 24);
  endtask

  // the ebreak at 0x100 only exists after the sd writes it
  task automatic test_ebreak_halt();
    clear_program();
    emit(enc_auipc(5'd5, 20'h0));
    emit(enc_lui(5'd1, 20'h00100));
    emit(enc_addi(5'd1, 5'd1, 12'h073));
    emit(enc_sd(5'd5, 5'd1, 12'h100));
    emit(enc_jal(5'd0, 21'h0f0));
    next_index = 64;
    emit(32'h0000_0000);
    expect_store('h100, 64'h0000_0000_0010_0073);
    reset_and_load();
    run_until_halt();
    compare_stores();
    check_halt(1'b0, 'h100);
  endtask

  task automatic test_illegal_random();
    logic [31:0] rnd;
    logic [4:0]  rd;
    logic [4:0]  rs_a;
    logic [4:0]  rs_b;
    int          off;
    int          stop_off;
    clear_program();
    model[0] = '0;
    emit(enc_auipc(5'd5, 20'h0));
    for (int r = 1; r <= 4; r++) begin
      rnd = $random(seed);
      emit(enc_addi(5'(r), 5'd0, rnd[11:0]));
      model[r] = sext12(rnd[11:0]);
    end
    // random addi / add mix over x0..x4
    for (int n = 0; n < 8; n++) begin
      rd   = pick_reg();
      rs_a = pick_reg();
      rs_b = pick_reg();
      rnd  = $random(seed);
      if (rnd[31]) begin
        emit(enc_add(rd, rs_a, rs_b));
        model[rd] = model[rs_a] + model[rs_b];
      end else begin
        emit(enc_addi(rd, rs_a, rnd[11:0]));
        model[rd] = model[rs_a] + sext12(rnd[11:0]);
      end
      model[0] = '0;
    end
    for (int r = 1; r <= 4; r++) begin
      off = 'h3f8 + 8 * r;
      emit(enc_sd(5'd5, 5'(r), 12'(off)));
      expect_store(off, model[r]);
    end
    // sub is outside the subset
    stop_off = 4 * next_index;
    emit({7'b0100000, 5'd2, 5'd1, 3'b000, 5'd3, 7'b0110011});
    emit(32'h0010_0073);
    reset_and_load();
    run_until_halt();
    compare_stores();
    check_halt(1'b1, stop_off);
  endtask

  initial begin
    clk         = 1'b0;
    rst_n       = 1'b0;
    prog_load   = '0;
    error_count = 0;
    check_count = 0;
    cycle_count = 0;
    test_reset_state();
    test_arithmetic();
    test_auipc_jal();
    test_ebreak_halt();
    test_illegal_random();
    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== rv_core.f ====
common/rv_core_pkg.sv
logic/fetch.sv
memory/unified_memory.sv
logic/decoder.sv
logic/reg_file.sv
logic/execute.sv
logic/rv_core_top.sv
verif/rv_core_assertions.sv
verif/rv_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the core testbench with verilator, run it and scan the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f rv_core.f \
  --top-module rv_core_tb \
  -o rv_core_sim

./obj_dir/rv_core_sim > sim.log 2>&1
cat sim.log

if grep -q "^Done: no errors$" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed, see sim.log"
  exit 1
fi
